// File: mmuTranslate.f
+incdir+include
design/mmuPkg.sv
design/oneHotEncoder.sv
design/tlbArray.sv
design/lookupStage.sv
design/checkStage.sv
design/mmuTranslate.sv
testbench/mmuTranslateTb.sv

// File: Bender.yml
package:
  name: mmuTranslate

sources:
  - files:
      - design/mmuPkg.sv
      - design/oneHotEncoder.sv
      - design/tlbArray.sv
      - design/lookupStage.sv
      - design/checkStage.sv
      - design/mmuTranslate.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/mmuTranslateTb.sv

// File: include/mmuTbModel.svh
`ifndef MMU_TB_MODEL_SVH
`define MMU_TB_MODEL_SVH

// one TLB entry as written through the CSRs
typedef struct packed {
    logic enable;
    mmuPkg::asid_t asid;
    mmuPkg::tlbCsr_t regs;
} modelEntry_t;

function automatic bit modelHit(modelEntry_t e, mmuPkg::vaddr_t addr, mmuPkg::asid_t asid);
    logic [31:0] mask;
    logic isGlobal;
    mask = 32'hFFFF_FFFF << (e.regs.tlbidx[29:24] + 6'd1);
    isGlobal = e.regs.tlbelo0[6] & e.regs.tlbelo1[6];
    return e.enable && (isGlobal || e.asid == asid)
        && (((e.regs.tlbehi & 32'hFFFF_E000) ^ addr) & mask) == 32'h0;
endfunction

function automatic bit modelWindow(logic [31:0] dmw, mmuPkg::plv_t plv, mmuPkg::vaddr_t addr);
    return ((dmw[0] && plv == 2'd0) || (dmw[3] && plv == 2'd3)) && dmw[31:29] == addr[31:29];
endfunction

// expected response for a valid request, hit entry chosen by the caller
function automatic mmuPkg::xlatResp_t modelTranslate(mmuPkg::xlatReq_t req,
    mmuPkg::csrView_t csr, bit hit, modelEntry_t e);
    mmuPkg::xlatResp_t r;
    logic [31:0] elo;
    logic [31:0] mask;
    logic [1:0] plv;
    r = '0;
    plv = csr.crmd[1:0];
    mask = 32'hFFFF_FFFF << e.regs.tlbidx[29:24];
    elo = req.addr[e.regs.tlbidx[28:24]] ? e.regs.tlbelo1 : e.regs.tlbelo0;
    r.valid = 1'b1;
    if (csr.crmd[4:3] == 2'b01)
    begin
        r.addr = req.addr;
        r.mat = (req.opType == mmuPkg::OP_FETCH) ? csr.crmd[6:5] : csr.crmd[8:7];
        return r;
    end
    if (modelWindow(csr.dmw0, plv, req.addr) || modelWindow(csr.dmw1, plv, req.addr))
    begin
        elo = modelWindow(csr.dmw0, plv, req.addr) ? csr.dmw0 : csr.dmw1;
        r.addr = {elo[27:25], req.addr[28:0]};
        r.mat = elo[5:4];
        return r;
    end
    r.addr = ({elo[27:8], 12'b0} & mask) | (req.addr & ~mask);
    r.mat = elo[5:4];
    r.excp.valid = 1'b1;
    r.valid = 1'b0;
    if (plv != 2'd0 && req.addr[31])
        r.excp.code = mmuPkg::EC_ADE;
    else if (!hit)
        r.excp.code = mmuPkg::EC_TLBR;
    else if (!elo[0])
        r.excp.code = (req.opType == mmuPkg::OP_FETCH) ? mmuPkg::EC_PIF
            : (req.opType == mmuPkg::OP_LOAD) ? mmuPkg::EC_PIL : mmuPkg::EC_PIS;
    else if (plv > elo[3:2])
        r.excp.code = mmuPkg::EC_PPI;
    else if (req.opType == mmuPkg::OP_STORE && !elo[1])
        r.excp.code = mmuPkg::EC_PME;
    else
        {r.valid, r.excp.valid} = 2'b10;
    if (r.excp.code == mmuPkg::EC_ADE && req.opType != mmuPkg::OP_FETCH)
        r.excp.subcode = mmuPkg::SUB_ADEM;
    return r;
endfunction

`endif

// File: testbench/mmuTranslateTb.sv
`timescale 1ns/1ps

module mmuTranslateTb;

`include "mmuTbModel.svh"

    localparam int indexWidth = 5;
    localparam int requestBudget = 250;  // about 190 requests plus commands and drains
    localparam logic [8:0] crmdDirect = 9'b01_10_0_1_0_00;
    localparam logic [8:0] crmdPlv0 = 9'b00_00_1_0_0_00;
    localparam logic [8:0] crmdPlv3 = 9'b00_00_1_0_0_11;
    localparam logic [31:0] dmw0Win = 32'hA400_0019;    // 0xa seg to 0x4, plv0 and plv3
    localparam logic [31:0] dmw1Win = 32'h6200_0021;    // 0x6 seg to 0x2, plv0 only

    logic clk;
    logic reset;
    mmuPkg::csrView_t csr;
    mmuPkg::xlatReq_t req;
    logic stall;
    logic flush;
    mmuPkg::xlatResp_t resp;
    mmuPkg::tlbCmd_t tlbCmd;
    mmuPkg::invOp_t invOp;
    mmuPkg::asid_t invAsid;
    mmuPkg::tlbCsr_t tlbCsrIn;
    logic [31:0] searchResult;

    modelEntry_t model [1 << indexWidth];
    mmuPkg::xlatResp_t expNext;
    mmuPkg::xlatResp_t exp1;
    mmuPkg::xlatResp_t exp2;
    mmuPkg::xlatResp_t respHeld;
    logic [31:0] searchExp;
    string testName;
    string name1;
    string name2;
    logic armed1;
    logic armed2;
    logic searchArmed;
    logic flushedLast;
    logic stalledLast;
    int respChecks;

    mmuTranslate #(.tlbIndexWidth(indexWidth)) mmuTranslate_i (
        .clk(clk),
        .reset(reset),
        .csr(csr),
        .req(req),
        .stall(stall),
        .flush(flush),
        .resp(resp),
        .tlbCmd(tlbCmd),
        .invOp(invOp),
        .invAsid(invAsid),
        .tlbCsrIn(tlbCsrIn),
        .searchResult(searchResult)
    );

    always #50 clk = ~clk;

    // expected responses follow the two edge latency
    always @(posedge clk)
    begin
        respHeld <= resp;
        stalledLast <= stall && !flush && !reset;
        flushedLast <= flush && !reset;
        searchArmed <= !reset && !stall && tlbCmd == mmuPkg::CMD_SEARCH;
        if (reset || flush)
        begin
            armed1 <= 1'b0;
            armed2 <= 1'b0;
        end
        else if (!stall)
        begin
            armed1 <= req.valid;
            exp1 <= expNext;
            name1 <= testName;
            armed2 <= armed1;
            exp2 <= exp1;
            name2 <= name1;
        end
    end

    always @(negedge clk)
    begin
        if (!reset && armed2)
            respChecks++;
    end

    task automatic reportMismatch(string name, logic [63:0] expected, logic [63:0] actual);
        $display("mismatch %s expected %h actual %h", name, expected, actual);
        $display("TEST FAIL");
        $fatal(1, "check failed in %s", name);
    endtask

    function automatic bit respMatches(mmuPkg::xlatResp_t e, mmuPkg::xlatResp_t a);
        if (a.valid !== e.valid || a.excp.valid !== e.excp.valid)
            return 1'b0;
        if (e.valid && (a.addr !== e.addr || a.mat !== e.mat))
            return 1'b0;
        if (e.excp.valid && (a.excp.code !== e.excp.code || a.excp.subcode !== e.excp.subcode))
            return 1'b0;
        return 1'b1;
    endfunction

    respCheck: assert property (@(negedge clk) disable iff (reset)
        armed2 |-> respMatches(exp2, resp))
    else
        reportMismatch(name2, exp2, resp);

    stallCheck: assert property (@(negedge clk) disable iff (reset)
        stalledLast |-> resp === respHeld)
    else
        reportMismatch("stall", respHeld, resp);

    flushCheck: assert property (@(negedge clk) disable iff (reset)
        flushedLast |-> !resp.valid && !resp.excp.valid)
    else
        reportMismatch("flush", 64'h0, {resp.valid, resp.excp.valid});

    searchCheck: assert property (@(negedge clk) disable iff (reset)
        searchArmed |-> searchResult === searchExp)
    else
        reportMismatch("search", searchExp, searchResult);

    function automatic mmuPkg::xlatResp_t expectFor(mmuPkg::xlatReq_t r);
        modelEntry_t e;
        bit hit;
        e = '0;
        hit = 1'b0;
        for (int i = 0; i < (1 << indexWidth); i++)
        begin
            if (!hit && modelHit(model[i], r.addr, csr.asid))
            begin
                e = model[i];
                hit = 1'b1;
            end
        end
        return modelTranslate(r, csr, hit, e);
    endfunction

    function automatic mmuPkg::opType_t randomOp();
        return mmuPkg::opType_t'($urandom % 3);
    endfunction

    // random address inside the page pair of a model entry
    function automatic mmuPkg::vaddr_t entryAddr(int idx);
        logic [31:0] mask;
        mask = 32'hFFFF_FFFF << (model[idx].regs.tlbidx[29:24] + 6'd1);
        return (model[idx].regs.tlbehi & mask) | ($urandom & ~mask);
    endfunction

    task automatic sendReq(mmuPkg::vaddr_t addr, mmuPkg::opType_t op);
        @(negedge clk);
        stall = 1'b0;
        flush = 1'b0;
        tlbCmd = mmuPkg::CMD_NONE;
        req.addr = addr;
        req.opType = op;
        req.valid = 1'b1;
        expNext = expectFor(req);
    endtask

    task automatic drain(int cycles);
        repeat (cycles)
        begin
            @(negedge clk);
            stall = 1'b0;
            flush = 1'b0;
            tlbCmd = mmuPkg::CMD_NONE;
            req.valid = 1'b0;
        end
    endtask

    task automatic setCsr(logic [8:0] crmd, mmuPkg::asid_t asid, logic [31:0] dmw0,
        logic [31:0] dmw1);
        drain(2);   // nothing in flight when csr moves
        csr.crmd = crmd;
        csr.asid = asid;
        csr.dmw0 = dmw0;
        csr.dmw1 = dmw1;
    endtask

    task automatic holdPipeline(int cycles);
        repeat (cycles)
        begin
            @(negedge clk);
            stall = 1'b1;
            req.addr = $urandom;
            req.valid = 1'b1;
        end
    endtask

    task automatic writeEntry(int idx, mmuPkg::asid_t asid, logic [31:0] ehi,
        logic [5:0] ps, logic ne, logic [31:0] elo0, logic [31:0] elo1);
        @(negedge clk);
        req.valid = 1'b0;
        csr.asid = asid;
        tlbCmd = idx[0] ? mmuPkg::CMD_FILL : mmuPkg::CMD_WRITE;
        tlbCsrIn.tlbidx = {ne, 1'b0, ps, 24'(idx)};
        tlbCsrIn.tlbehi = ehi;
        tlbCsrIn.tlbelo0 = elo0;
        tlbCsrIn.tlbelo1 = elo1;
        model[idx].enable = !ne;
        model[idx].asid = asid;
        model[idx].regs = tlbCsrIn;
    endtask

    task automatic writeRandom(int idx, mmuPkg::asid_t asid);
        logic [31:0] elo0;
        logic [31:0] elo1;
        logic glob;
        glob = ($urandom % 4) == 0;
        elo0 = ($urandom & 32'h0FFF_FFBF) | {25'b0, glob, 6'b0};
        elo1 = ($urandom & 32'h0FFF_FFBF) | {25'b0, glob, 6'b0};
        // region bits 30:26 follow the index so entries never overlap
        writeEntry(idx, asid, {1'b0, 5'(idx), 26'($urandom)}, 6'(12 + $urandom % 10),
            ($urandom % 8) == 0, elo0, elo1);
    endtask

    task automatic searchFor(logic [31:0] ehi);
        @(negedge clk);
        req.valid = 1'b0;
        tlbCmd = mmuPkg::CMD_SEARCH;
        tlbCsrIn.tlbehi = ehi;
        searchExp = 32'h8000_0000;   // miss
        for (int i = (1 << indexWidth) - 1; i >= 0; i--)
        begin
            if (modelHit(model[i], ehi, csr.asid))
                searchExp = i;
        end
        @(negedge clk);
        tlbCmd = mmuPkg::CMD_NONE;
    endtask

    task automatic invalidate(mmuPkg::invOp_t op, mmuPkg::asid_t asid);
        logic glob;
        logic kill;
        @(negedge clk);
        req.valid = 1'b0;
        tlbCmd = mmuPkg::CMD_INVALIDATE;
        invOp = op;
        invAsid = asid;
        for (int i = 0; i < (1 << indexWidth); i++)
        begin
            glob = model[i].regs.tlbelo0[6] & model[i].regs.tlbelo1[6];
            case (op)
                5'd0, 5'd1: kill = 1'b1;
                5'd2: kill = glob;
                5'd3: kill = !glob;
                default: kill = !glob && model[i].asid == asid;
            endcase
            if (kill)
                model[i].enable = 1'b0;
        end
        @(negedge clk);
        tlbCmd = mmuPkg::CMD_NONE;
    endtask

    initial
    begin
        repeat ((requestBudget * 2) + 100) @(posedge clk);
        $display("watchdog expired before the tests finished");
        $display("TEST FAIL");
        $fatal(1, "timeout");
    end

    initial
    begin
        void'($urandom(8514));
        clk = 1'b0;
        reset = 1'b1;
        csr = '0;
        req = '0;
        stall = 1'b0;
        flush = 1'b0;
        tlbCmd = mmuPkg::CMD_NONE;
        invOp = '0;
        invAsid = '0;
        tlbCsrIn = '0;
        expNext = '0;
        searchExp = '0;
        armed1 = 1'b0;
        armed2 = 1'b0;
        searchArmed = 1'b0;
        flushedLast = 1'b0;
        stalledLast = 1'b0;
        respChecks = 0;
        testName = "reset";
        for (int i = 0; i < (1 << indexWidth); i++)
            model[i] = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        testName = "direct";
        setCsr(crmdDirect, 10'h05A, 32'h0, 32'h0);
        repeat (8) sendReq($urandom, randomOp());

        testName = "window";
        setCsr(crmdPlv0, 10'h05A, dmw0Win, dmw1Win);
        for (int i = 0; i < 4; i++)
        begin
            sendReq({3'b101, 29'($urandom)}, randomOp());
            sendReq({3'b011, 29'($urandom)}, randomOp());
        end
        setCsr(crmdPlv3, 10'h05A, dmw0Win, dmw1Win);
        for (int i = 0; i < 3; i++)
        begin
            sendReq({3'b101, 29'($urandom)}, randomOp());
            sendReq({3'b011, 29'($urandom)}, randomOp());   // no plv3 window, refill
            sendReq({3'b100, 29'($urandom)}, randomOp());   // address error
        end

        // clean valid even page, invalid odd page, 4 KiB
        testName = "tlb fixed";
        setCsr(crmdPlv0, 10'h05A, 32'h0, 32'h0);
        writeEntry(0, 10'h05A, 32'h0, 6'd12, 1'b0, 32'h0123_4511, 32'h0543_2110);
        sendReq(32'h0000_0ABC, mmuPkg::OP_LOAD);
        sendReq(32'h0000_0ABC, mmuPkg::OP_STORE);
        sendReq(32'h0000_1ABC, mmuPkg::OP_FETCH);
        sendReq(32'h0000_1ABC, mmuPkg::OP_LOAD);
        sendReq(32'h0000_1ABC, mmuPkg::OP_STORE);
        setCsr(crmdPlv3, 10'h05A, 32'h0, 32'h0);
        sendReq(32'h0000_0ABC, mmuPkg::OP_LOAD);
        sendReq(32'h8000_0ABC, mmuPkg::OP_FETCH);
        sendReq(32'h8000_0ABC, mmuPkg::OP_STORE);

        testName = "tlb random";
        setCsr(crmdPlv0, 10'h05A, 32'h0, 32'h0);
        for (int i = 0; i < 8; i++)
            writeRandom(4 * i + 1, 10'h05A);
        for (int p = 0; p < 2; p++)
        begin
            setCsr(p == 0 ? crmdPlv0 : crmdPlv3, 10'h05A, 32'h0, 32'h0);
            for (int i = 0; i < 8; i++)
                repeat (4) sendReq(entryAddr(4 * i + 1), randomOp());
        end

        setCsr(crmdPlv0, 10'h05A, 32'h0, 32'h0);
        for (int i = 0; i < 9; i++)
            searchFor(model[i == 8 ? 0 : 4 * i + 1].regs.tlbehi);
        setCsr(crmdPlv0, 10'h0A5, 32'h0, 32'h0);   // only global entries still match
        for (int i = 0; i < 9; i++)
            searchFor(model[i == 8 ? 0 : 4 * i + 1].regs.tlbehi);

        for (int op = 4; op >= 0; op--)
        begin
            testName = $sformatf("invalidate %0d", op);
            drain(2);
            for (int i = 0; i < 8; i++)
                writeRandom(4 * i + 1, i[0] ? 10'h0A5 : 10'h05A);
            invalidate(5'(op), 10'h05A);
            setCsr(crmdPlv0, 10'h05A, 32'h0, 32'h0);
            for (int i = 0; i < 8; i++)
                sendReq(entryAddr(4 * i + 1), mmuPkg::OP_LOAD);
            setCsr(crmdPlv0, 10'h0A5, 32'h0, 32'h0);
            for (int i = 0; i < 8; i++)
                sendReq(entryAddr(4 * i + 1), mmuPkg::OP_LOAD);
        end

        testName = "stall flush";
        setCsr(crmdDirect, 10'h05A, 32'h0, 32'h0);
        sendReq($urandom, randomOp());
        sendReq($urandom, randomOp());
        holdPipeline(3);
        sendReq($urandom, randomOp());
        sendReq($urandom, randomOp());
        sendReq($urandom, randomOp());
        @(negedge clk);
        flush = 1'b1;
        stall = 1'b1;   // flush wins
        req.valid = 1'b1;
        sendReq($urandom, randomOp());
        drain(3);

        if (respChecks > 0)
        begin
            $display("TEST PASS");
            $finish;
        end
        else
        begin
            $display("no response was checked");
            $display("TEST FAIL");
            $fatal(1, "empty run");
        end
    end

endmodule

// File: design/mmuTranslate.sv
`timescale 1ns/1ps

module mmuTranslate #(
    parameter int tlbIndexWidth = 5
) (
    input logic clk,
    input logic reset,
    input mmuPkg::csrView_t csr,
    input mmuPkg::xlatReq_t req,
    input logic stall,
    input logic flush,
    output mmuPkg::xlatResp_t resp,
    input mmuPkg::tlbCmd_t tlbCmd,
    input mmuPkg::invOp_t invOp,
    input mmuPkg::asid_t invAsid,
    input mmuPkg::tlbCsr_t tlbCsrIn,
    output logic [31:0] searchResult
);

    mmuPkg::tlbPage_t lookupPage;
    mmuPkg::stageRec_t stageRec;

    // lookup runs on the incoming request, result lands in stage 1
    tlbArray #(.tlbIndexWidth(tlbIndexWidth)) tlbArray_i (
        .clk(clk),
        .reset(reset),
        .stall(stall),
        .tlbCmd(tlbCmd),
        .invOp(invOp),
        .invAsid(invAsid),
        .tlbCsrIn(tlbCsrIn),
        .asid(csr.asid),
        .lookupAddr(req.addr),
        .lookupPage(lookupPage),
        .searchResult(searchResult)
    );

    lookupStage lookupStage_i (
        .clk(clk),
        .reset(reset),
        .stall(stall),
        .flush(flush),
        .req(req),
        .csr(csr),
        .lookupPage(lookupPage),
        .stageOut(stageRec)
    );

    checkStage checkStage_i (
        .clk(clk),
        .reset(reset),
        .stall(stall),
        .flush(flush),
        .stageIn(stageRec),
        .csr(csr),
        .resp(resp)
    );

endmodule

// File: design/checkStage.sv
`timescale 1ns/1ps

module checkStage (
    input logic clk,
    input logic reset,
    input logic stall,
    input logic flush,
    input mmuPkg::stageRec_t stageIn,
    input mmuPkg::csrView_t csr,
    output mmuPkg::xlatResp_t resp
);

    mmuPkg::xlatResp_t respNext;
    mmuPkg::xlatReq_t req;
    mmuPkg::tlbPage_t page;
    mmuPkg::plv_t plv;
    mmuPkg::ecode_t code;
    mmuPkg::esubcode_t subcode;
    logic [31:0] pageMask;
    logic isFetch;
    logic raise;

    assign req = stageIn.req;
    assign page = stageIn.page;
    assign plv = csr.crmd[1:0];
    assign isFetch = req.opType == mmuPkg::OP_FETCH;
    assign pageMask = 32'hFFFF_FFFF << page.ps;

    always_comb
    begin
        raise = 1'b0;
        code = '0;
        subcode = '0;
        respNext.addr = req.addr;
        respNext.mat = page.mat;
        case (stageIn.mode)
            mmuPkg::MODE_DIRECT:
                respNext.mat = isFetch ? csr.crmd[6:5] : csr.crmd[8:7];  // datf / datm
            mmuPkg::MODE_DMW0, mmuPkg::MODE_DMW1:
            begin
                respNext.addr = {stageIn.winSeg, req.addr[28:0]};
                respNext.mat = stageIn.winMat;
            end
            mmuPkg::MODE_TLB:
            begin
                respNext.addr = ({page.ppn, 12'b0} & pageMask) | (req.addr & ~pageMask);
                raise = 1'b1;
                if (plv != 2'd0 && req.addr[31])
                begin
                    code = mmuPkg::EC_ADE;
                    subcode = isFetch ? mmuPkg::SUB_ADEF : mmuPkg::SUB_ADEM;
                end
                else if (!page.hit)
                    code = mmuPkg::EC_TLBR;
                else if (!page.valid)
                begin
                    if (isFetch)
                        code = mmuPkg::EC_PIF;
                    else if (req.opType == mmuPkg::OP_LOAD)
                        code = mmuPkg::EC_PIL;
                    else
                        code = mmuPkg::EC_PIS;
                end
                else if (plv > page.plv)
                    code = mmuPkg::EC_PPI;
                else if (req.opType == mmuPkg::OP_STORE && !page.dirty)
                    code = mmuPkg::EC_PME;
                else
                    raise = 1'b0;
            end
            default:
                raise = 1'b0;
        endcase
        respNext.valid = req.valid && !raise;
        respNext.excp.valid = req.valid && raise;
        respNext.excp.subcode = subcode;
        respNext.excp.code = code;
    end

    always_ff @(posedge clk)
    begin
        if (reset || flush)
        begin
            resp.valid <= 1'b0;
            resp.excp.valid <= 1'b0;
        end
        else if (!stall)
        begin
            resp <= respNext;
        end
    end

    // a translation either succeeds or traps
    respExclusive: assert property (
        @(posedge clk) disable iff (reset) !(resp.valid && resp.excp.valid)
    );

endmodule

// File: design/lookupStage.sv
`timescale 1ns/1ps

module lookupStage (
    input logic clk,
    input logic reset,
    input logic stall,
    input logic flush,
    input mmuPkg::xlatReq_t req,
    input mmuPkg::csrView_t csr,
    input mmuPkg::tlbPage_t lookupPage,
    output mmuPkg::stageRec_t stageOut
);

    mmuPkg::stageRec_t stageNext;
    mmuPkg::plv_t plv;
    logic directMode;
    logic dmw0Hit;
    logic dmw1Hit;

    // plv0 enable in bit 0, plv3 enable in bit 3
    function automatic logic windowHit(logic [31:0] dmw, mmuPkg::plv_t curPlv,
        mmuPkg::vaddr_t addr);
        logic plvOk;
        plvOk = (dmw[0] && curPlv == 2'd0) || (dmw[3] && curPlv == 2'd3);
        return plvOk && dmw[31:29] == addr[31:29];
    endfunction

    assign plv = csr.crmd[1:0];
    assign directMode = csr.crmd[4:3] == 2'b01;   // da=1, pg=0
    assign dmw0Hit = windowHit(csr.dmw0, plv, req.addr);
    assign dmw1Hit = windowHit(csr.dmw1, plv, req.addr);

    always_comb
    begin
        stageNext.req = req;
        stageNext.page = lookupPage;
        stageNext.winSeg = csr.dmw0[27:25];
        stageNext.winMat = csr.dmw0[5:4];
        if (directMode)
        begin
            stageNext.mode = mmuPkg::MODE_DIRECT;
        end
        else if (dmw0Hit)
        begin
            stageNext.mode = mmuPkg::MODE_DMW0;
        end
        else if (dmw1Hit)
        begin
            stageNext.mode = mmuPkg::MODE_DMW1;
            stageNext.winSeg = csr.dmw1[27:25];
            stageNext.winMat = csr.dmw1[5:4];
        end
        else
        begin
            stageNext.mode = mmuPkg::MODE_TLB;
        end
    end

    // flush wins over stall
    always_ff @(posedge clk)
    begin
        if (reset || flush)
            stageOut.req.valid <= 1'b0;
        else if (!stall)
            stageOut <= stageNext;
    end

    stageValidKnown: assert property (
        @(posedge clk) disable iff (reset) !$isunknown(stageOut.req.valid)
    );

endmodule

// File: design/tlbArray.sv
`timescale 1ns/1ps

module tlbArray #(
    parameter int tlbIndexWidth = 5
) (
    input logic clk,
    input logic reset,
    input logic stall,
    input mmuPkg::tlbCmd_t tlbCmd,
    input mmuPkg::invOp_t invOp,
    input mmuPkg::asid_t invAsid,
    input mmuPkg::tlbCsr_t tlbCsrIn,
    input mmuPkg::asid_t asid,
    input mmuPkg::vaddr_t lookupAddr,
    output mmuPkg::tlbPage_t lookupPage,
    output logic [31:0] searchResult
);

    localparam int entryCount = 1 << tlbIndexWidth;

    typedef struct packed {
        mmuPkg::ppn_t ppn;
        mmuPkg::plv_t plv;
        mmuPkg::mat_t mat;
        logic dirty;
        logic valid;
    } tlbHalf_t;

    typedef struct packed {
        mmuPkg::vppn_t vppn;
        mmuPkg::pageShift_t ps;
        logic isGlobal;
        mmuPkg::asid_t asid;
        tlbHalf_t even;
        tlbHalf_t odd;
    } tlbEntry_t;

    tlbEntry_t entries [entryCount];
    tlbEntry_t newEntry;
    tlbEntry_t hitEntry;
    tlbHalf_t hitHalf;
    logic [entryCount - 1:0] enable;
    logic [entryCount - 1:0] lookupHits;
    logic [entryCount - 1:0] searchHits;
    logic [entryCount - 1:0] invMask;
    logic [tlbIndexWidth - 1:0] writeIndex;
    logic [tlbIndexWidth - 1:0] lookupIndex;
    logic [tlbIndexWidth - 1:0] searchIndex;
    logic cmdActive;
    logic isWrite;

    // vppn compare above bit ps+1, the pair shares one tag
    function automatic logic vpnMatch(tlbEntry_t e, mmuPkg::vaddr_t addr);
        logic [31:0] mask;
        mask = 32'hFFFF_FFFF << (e.ps + 6'd1);
        return ((({e.vppn, 13'b0}) ^ addr) & mask) == 32'h0;
    endfunction

    always_comb
    begin
        for (int i = 0; i < entryCount; i++)
        begin
            lookupHits[i] = enable[i] && (entries[i].isGlobal || entries[i].asid == asid)
                && vpnMatch(entries[i], lookupAddr);
            searchHits[i] = enable[i] && (entries[i].isGlobal || entries[i].asid == asid)
                && vpnMatch(entries[i], tlbCsrIn.tlbehi);
        end
    end

    oneHotEncoder #(.tlbIndexWidth(tlbIndexWidth)) lookupEncoder_i (
        .hits(lookupHits),
        .index(lookupIndex)
    );

    oneHotEncoder #(.tlbIndexWidth(tlbIndexWidth)) searchEncoder_i (
        .hits(searchHits),
        .index(searchIndex)
    );

    always_comb
    begin
        hitEntry = entries[lookupIndex];
        hitHalf = lookupAddr[hitEntry.ps[4:0]] ? hitEntry.odd : hitEntry.even; // odd page
        lookupPage.hit = |lookupHits;
        lookupPage.ppn = hitHalf.ppn;
        lookupPage.ps = hitEntry.ps;
        lookupPage.plv = hitHalf.plv;
        lookupPage.mat = hitHalf.mat;
        lookupPage.dirty = hitHalf.dirty;
        lookupPage.valid = hitHalf.valid;
    end

    assign cmdActive = !stall && (tlbCmd != mmuPkg::CMD_NONE);
    assign isWrite = cmdActive && (tlbCmd == mmuPkg::CMD_WRITE || tlbCmd == mmuPkg::CMD_FILL);
    assign writeIndex = tlbCsrIn.tlbidx[tlbIndexWidth - 1:0];

    always_comb
    begin
        newEntry.vppn = tlbCsrIn.tlbehi[31:13];
        newEntry.ps = tlbCsrIn.tlbidx[29:24];
        newEntry.isGlobal = tlbCsrIn.tlbelo0[6] & tlbCsrIn.tlbelo1[6];
        newEntry.asid = asid;
        newEntry.even = {tlbCsrIn.tlbelo0[27:8], tlbCsrIn.tlbelo0[3:2],
            tlbCsrIn.tlbelo0[5:4], tlbCsrIn.tlbelo0[1], tlbCsrIn.tlbelo0[0]};
        newEntry.odd = {tlbCsrIn.tlbelo1[27:8], tlbCsrIn.tlbelo1[3:2],
            tlbCsrIn.tlbelo1[5:4], tlbCsrIn.tlbelo1[1], tlbCsrIn.tlbelo1[0]};
    end

    always_comb
    begin
        for (int i = 0; i < entryCount; i++)
        begin
            case (invOp)
                5'd0, 5'd1: invMask[i] = 1'b1;
                5'd2: invMask[i] = entries[i].isGlobal;
                5'd3: invMask[i] = !entries[i].isGlobal;
                5'd4: invMask[i] = !entries[i].isGlobal && entries[i].asid == invAsid;
                default: invMask[i] = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (isWrite)
            entries[writeIndex] <= newEntry;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            enable <= '0;
        else if (isWrite)
            enable[writeIndex] <= ~tlbCsrIn.tlbidx[31];   // NE
        else if (cmdActive && tlbCmd == mmuPkg::CMD_INVALIDATE)
            enable <= enable & ~invMask;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            searchResult <= 32'h0;
        else if (cmdActive && tlbCmd == mmuPkg::CMD_SEARCH)
            searchResult <= {~|searchHits, {(31 - tlbIndexWidth){1'b0}}, searchIndex};
    end

    // overlapping entries would corrupt the encoder output
    lookupOneHot: assert property (@(posedge clk) disable iff (reset) $onehot0(lookupHits));

endmodule

// File: design/oneHotEncoder.sv
`timescale 1ns/1ps

module oneHotEncoder #(
    parameter int tlbIndexWidth = 5
) (
    input logic [(1 << tlbIndexWidth) - 1:0] hits,
    output logic [tlbIndexWidth - 1:0] index
);

    // level k keeps the half still holding the hit in its low 2^k bits
    logic [(1 << tlbIndexWidth) - 1:0] level [0:tlbIndexWidth];

    assign level[tlbIndexWidth] = hits;

    for (genvar i = 0; i < tlbIndexWidth; i++)
    begin : genLevel
        assign index[i] = |level[i + 1][(2 << i) - 1:(1 << i)];
        assign level[i] = index[i] ? (level[i + 1] >> (1 << i)) : level[i + 1];
    end

endmodule

// File: design/mmuPkg.sv
package mmuPkg;

    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] paddr_t;
    typedef logic [9:0] asid_t;
    typedef logic [1:0] plv_t;
    typedef logic [1:0] mat_t;
    typedef logic [5:0] pageShift_t;
    typedef logic [19:0] ppn_t;
    typedef logic [18:0] vppn_t;

    typedef logic [1:0] opType_t;
    localparam opType_t OP_FETCH = 2'd0;
    localparam opType_t OP_LOAD = 2'd1;
    localparam opType_t OP_STORE = 2'd2;

    typedef logic [2:0] tlbCmd_t;
    localparam tlbCmd_t CMD_NONE = 3'd0;
    localparam tlbCmd_t CMD_SEARCH = 3'd1;
    localparam tlbCmd_t CMD_WRITE = 3'd3;
    localparam tlbCmd_t CMD_FILL = 3'd4;
    localparam tlbCmd_t CMD_INVALIDATE = 3'd5;

    typedef logic [4:0] invOp_t;

    typedef logic [5:0] ecode_t;
    localparam ecode_t EC_PIL = 6'h01;
    localparam ecode_t EC_PIS = 6'h02;
    localparam ecode_t EC_PIF = 6'h03;
    localparam ecode_t EC_PME = 6'h04;
    localparam ecode_t EC_PPI = 6'h07;
    localparam ecode_t EC_ADE = 6'h08;
    localparam ecode_t EC_TLBR = 6'h3F;

    typedef logic [8:0] esubcode_t;
    localparam esubcode_t SUB_ADEF = 9'h000;
    localparam esubcode_t SUB_ADEM = 9'h001;

    // translation mode picked in the first stage
    typedef logic [1:0] xlatMode_t;
    localparam xlatMode_t MODE_DIRECT = 2'd0;
    localparam xlatMode_t MODE_DMW0 = 2'd1;
    localparam xlatMode_t MODE_DMW1 = 2'd2;
    localparam xlatMode_t MODE_TLB = 2'd3;

    typedef struct packed {
        logic valid;
        esubcode_t subcode;
        ecode_t code;
    } excp_t;

    typedef struct packed {
        vaddr_t addr;
        opType_t opType;
        logic valid;
    } xlatReq_t;

    typedef struct packed {
        paddr_t addr;
        mat_t mat;
        logic valid;
        excp_t excp;
    } xlatResp_t;

    typedef struct packed {
        logic [8:0] crmd;   // plv, ie, da, pg, datf, datm
        asid_t asid;
        logic [31:0] dmw0;
        logic [31:0] dmw1;
    } csrView_t;

    typedef struct packed {
        logic [31:0] tlbidx;
        logic [31:0] tlbehi;
        logic [31:0] tlbelo0;
        logic [31:0] tlbelo1;
    } tlbCsr_t;

    typedef struct packed {
        logic hit;
        ppn_t ppn;
        pageShift_t ps;
        plv_t plv;
        mat_t mat;
        logic dirty;
        logic valid;
    } tlbPage_t;

    typedef struct packed {
        xlatReq_t req;
        xlatMode_t mode;
        logic [2:0] winSeg;  // physical segment of the hit window
        mat_t winMat;
        tlbPage_t page;
    } stageRec_t;

endpackage
